// File: common/imem_pkg.sv
// Shared widths, privilege and FSM enums, config/result structs and BIU protection bits
package imem_pkg;

  ////////////////////////////////////////
  // Widths and counts
  ////////////////////////////////////////

  localparam int XLEN = 32;
  localparam int PLEN = 32;

  // Data word and physical address
  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [PLEN-1:0] paddr_t;

  // Region and entry counts
  localparam int PMA_CNT     = 3;
  localparam int PMP_CNT     = 4;

  // Fetches in flight and queue bookkeeping widths
  localparam int QUEUE_DEPTH = 2;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  // Flushed responses still owed by the bus
  localparam int                DROP_W   = 2;
  localparam logic [DROP_W-1:0] DROP_MAX = '1;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  // Only user and machine mode
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_M = 2'b11
  } prv_e;

  // BIU strobe FSM
  typedef enum logic [1:0] {
    IDLE,
    STROBE,
    WAIT_DATA
  } fetch_state_e;

  ////////////////////////////////////////
  // Structs and protection bits
  ////////////////////////////////////////

  // Region upper bound is exclusive, lower bound is previous region's bound
  typedef struct packed {
    logic valid;
    logic exec;
  } pma_cfg_t;

  // Top-of-range PMP entry attributes
  typedef struct packed {
    logic lock;
    logic tor;
    logic exec;
  } pmp_cfg_t;

  // Bit 0 instruction, bit 1 privileged
  typedef logic [1:0] biu_prot_t;
  localparam biu_prot_t PROT_INSTRUCTION = 2'b01;
  localparam biu_prot_t PROT_PRIVILEGED  = 2'b10;

  // Checker verdict per fetch
  typedef struct packed {
    logic misaligned;
    logic pma_fault;
    logic pmp_fault;
  } chk_result_t;

  // Returned instruction parcel
  typedef struct packed {
    paddr_t pc;
    xlen_t  data;
    logic   error;
    logic   misaligned;
  } parcel_t;

endpackage

// File: hdl/imem_pma_chk.sv
// Word alignment check and PMA region lookup for a fetch address
`timescale 1ns/100ps

module imem_pma_chk
(
  // Region table
  input  imem_pkg::pma_cfg_t pma_cfg_i   [imem_pkg::PMA_CNT],
  input  imem_pkg::paddr_t   pma_bound_i [imem_pkg::PMA_CNT],

  // Fetch address
  input  imem_pkg::paddr_t   adr_i,

  // Verdict
  output logic               misaligned_o,
  output logic               fault_o
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Some valid region holds the address
  logic hit;
  // Executable bit of that region
  logic hit_exec;

  ////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////

  // No compressed parcels, fetches are whole words
  assign misaligned_o = |adr_i[1:0];

  ////////////////////////////////////////
  // Region search
  ////////////////////////////////////////

  // Regions are contiguous, each starting where the previous one ends
  always_comb
  begin : region_search
    imem_pkg::paddr_t lo;

    lo       = '0;
    hit      = 1'b0;
    hit_exec = 1'b0;

    for (int i = 0; i < imem_pkg::PMA_CNT; i++)
    begin
      // First valid region wins
      if (!hit && pma_cfg_i[i].valid &&
          (adr_i >= lo) && (adr_i < pma_bound_i[i]))
      begin
        hit      = 1'b1;
        hit_exec = pma_cfg_i[i].exec;
      end

      // Next region's lower bound
      lo = pma_bound_i[i];
    end
  end

  // Unmapped or non-executable memory
  assign fault_o = ~hit | ~hit_exec;

endmodule

// File: hdl/imem_pmp_chk.sv
// PMP top-of-range lookup with privilege and lock rules for instruction fetch
`timescale 1ns/100ps

module imem_pmp_chk
(
  // Entry table, addresses are byte bounds
  input  imem_pkg::pmp_cfg_t pmp_cfg_i  [imem_pkg::PMP_CNT],
  input  imem_pkg::paddr_t   pmp_addr_i [imem_pkg::PMP_CNT],

  // Current privilege and fetch address
  input  imem_pkg::prv_e     prv_i,
  input  imem_pkg::paddr_t   adr_i,

  output logic               fault_o
);

  // Matching entry and its attributes
  logic hit;
  logic hit_lock;
  logic hit_exec;

  ////////////////////////////////////////
  // Entry search
  ////////////////////////////////////////

  // TOR lower bound is previous entry's address, whatever its mode
  always_comb
  begin : entry_search
    imem_pkg::paddr_t lo;

    lo       = '0;
    hit      = 1'b0;
    hit_lock = 1'b0;
    hit_exec = 1'b0;

    for (int i = 0; i < imem_pkg::PMP_CNT; i++)
    begin
      // Lowest numbered enabled entry has priority
      if (!hit && pmp_cfg_i[i].tor &&
          (adr_i >= lo) && (adr_i < pmp_addr_i[i]))
      begin
        hit      = 1'b1;
        hit_lock = pmp_cfg_i[i].lock;
        hit_exec = pmp_cfg_i[i].exec;
      end

      lo = pmp_addr_i[i];
    end
  end

  // Machine mode bound only by locked entries
  // User mode needs a matching entry with execute
  assign fault_o = (prv_i == imem_pkg::PRV_M) ? (hit & hit_lock & ~hit_exec)
                                              : (~hit | ~hit_exec);

endmodule

// File: fetch/imem_fetch_core.sv
// In-order fetch queue, BIU strobe FSM, flush drop counter and parcel return register
`timescale 1ns/100ps

module imem_fetch_core
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // CPU side
  input  logic                  mem_req_i,
  input  imem_pkg::paddr_t      mem_adr_i,
  input  logic                  mem_flush_i,
  input  imem_pkg::chk_result_t chk_i,
  input  imem_pkg::biu_prot_t   prot_i,
  output logic                  mem_ack_o,
  output logic                  parcel_valid_o,
  output imem_pkg::parcel_t     parcel_o,

  // BIU side
  output logic                  biu_stb_o,
  input  logic                  biu_stb_ack_i,
  output imem_pkg::paddr_t      biu_adr_o,
  output imem_pkg::biu_prot_t   biu_prot_o,
  input  logic                  biu_ack_i,
  input  logic                  biu_err_i,
  input  imem_pkg::xlen_t       biu_q_i
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Queue storage and pointers
  imem_pkg::paddr_t            q_adr [imem_pkg::QUEUE_DEPTH];
  imem_pkg::chk_result_t       q_chk [imem_pkg::QUEUE_DEPTH];
  logic [imem_pkg::QPTR_W-1:0] wr_ptr;
  logic [imem_pkg::QPTR_W-1:0] rd_ptr;
  logic [imem_pkg::QCNT_W-1:0] q_cnt;

  // BIU FSM, strobe left over from a flush
  imem_pkg::fetch_state_e      state;
  logic                        stb_orphan;
  // Responses owed to flushed accesses
  logic [imem_pkg::DROP_W-1:0] drop_cnt;

  // Head of queue
  imem_pkg::paddr_t            head_adr;
  imem_pkg::chk_result_t       head_chk;
  logic                        head_fault;

  logic q_empty;
  logic q_full;
  logic push;
  logic issue;
  logic resp;
  logic resp_drop;
  logic resp_live;
  logic fault_pop;
  logic pop;
  logic live_busy;
  logic drop_inc;

  ////////////////////////////////////////
  // Control terms
  ////////////////////////////////////////

  assign q_empty = (q_cnt == '0);
  assign q_full  = (q_cnt == imem_pkg::QCNT_W'(imem_pkg::QUEUE_DEPTH));

  // Accept when there is room and no flush this cycle
  assign mem_ack_o = mem_req_i & ~q_full & ~mem_flush_i;
  assign push      = mem_ack_o;

  assign head_adr   = q_adr[rd_ptr];
  assign head_chk   = q_chk[rd_ptr];
  assign head_fault = head_chk.misaligned | head_chk.pma_fault | head_chk.pmp_fault;

  // Clean head goes to the bus, drop counter must not overflow
  assign issue = (state == imem_pkg::IDLE) & ~q_empty & ~head_fault & ~mem_flush_i &
                 (drop_cnt != imem_pkg::DROP_MAX);

  // Responses are in order, stale ones come first
  assign resp      = biu_ack_i | biu_err_i;
  assign resp_drop = resp & (drop_cnt != '0);
  assign resp_live = resp & (drop_cnt == '0) & (state == imem_pkg::WAIT_DATA);

  // Faulted head never touches the bus
  assign fault_pop = ~q_empty & head_fault;
  assign pop       = resp_live | fault_pop;

  // Access whose response becomes stale if flushed now
  assign live_busy = ((state == imem_pkg::STROBE) & ~stb_orphan) |
                     ((state == imem_pkg::WAIT_DATA) & ~resp_live);
  assign drop_inc  = mem_flush_i & live_busy;

  ////////////////////////////////////////
  // Fetch queue
  ////////////////////////////////////////

  // Address and check result stored at accept
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      q_adr[wr_ptr] <= mem_adr_i;
      q_chk[wr_ptr] <= chk_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || mem_flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end
    else
    begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;

      if (push && !pop)
        q_cnt <= q_cnt + 1'b1;
      else if (!push && pop)
        q_cnt <= q_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////
  // BIU strobe FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state      <= imem_pkg::IDLE;
      stb_orphan <= 1'b0;
    end
    else
    begin
      case (state)
        imem_pkg::IDLE:
          if (issue) state <= imem_pkg::STROBE;

        // Strobe always runs to its ack, even after a flush
        imem_pkg::STROBE:
          if (biu_stb_ack_i)
          begin
            state      <= (stb_orphan || mem_flush_i) ? imem_pkg::IDLE
                                                      : imem_pkg::WAIT_DATA;
            stb_orphan <= 1'b0;
          end
          else if (mem_flush_i)
            stb_orphan <= 1'b1;

        // Flush leaves the response to the drop counter
        imem_pkg::WAIT_DATA:
          if (resp_live || mem_flush_i) state <= imem_pkg::IDLE;

        default:
          state <= imem_pkg::IDLE;
      endcase
    end
  end

  assign biu_stb_o = (state == imem_pkg::STROBE);

  // Held stable for the whole strobe
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      biu_adr_o  <= head_adr;
      biu_prot_o <= prot_i;
    end
  end

  // Count up on flushed accesses, down on stale responses
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      drop_cnt <= '0;
    else
      drop_cnt <= drop_cnt + imem_pkg::DROP_W'(drop_inc) - imem_pkg::DROP_W'(resp_drop);
  end

  ////////////////////////////////////////
  // Parcel return
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      parcel_valid_o <= 1'b0;
    else
      parcel_valid_o <= pop & ~mem_flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (pop)
    begin
      parcel_o.pc <= head_adr;
      if (fault_pop)
      begin
        // Verdict straight from the checkers
        parcel_o.data       <= '0;
        parcel_o.error      <= 1'b1;
        parcel_o.misaligned <= head_chk.misaligned;
      end
      else
      begin
        // Bus error returns zero data
        parcel_o.data       <= biu_err_i ? '0 : biu_q_i;
        parcel_o.error      <= biu_err_i;
        parcel_o.misaligned <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/imem_ctrl.sv
// Instruction memory access top: protection bits, PMA/PMP checkers and fetch core
`timescale 1ns/100ps

module imem_ctrl
(
  input  logic                clk_i,
  input  logic                rst_n_i,

  // Configuration
  input  imem_pkg::pma_cfg_t  pma_cfg_i   [imem_pkg::PMA_CNT],
  input  imem_pkg::paddr_t    pma_bound_i [imem_pkg::PMA_CNT],
  input  imem_pkg::pmp_cfg_t  pmp_cfg_i   [imem_pkg::PMP_CNT],
  input  imem_pkg::paddr_t    pmp_addr_i  [imem_pkg::PMP_CNT],
  input  imem_pkg::prv_e      prv_i,

  // CPU side
  input  logic                mem_req_i,
  input  imem_pkg::paddr_t    mem_adr_i,
  input  logic                mem_flush_i,
  output logic                mem_ack_o,
  output logic                parcel_valid_o,
  output imem_pkg::parcel_t   parcel_o,

  // BIU side
  output logic                biu_stb_o,
  output imem_pkg::paddr_t    biu_adr_o,
  output imem_pkg::biu_prot_t biu_prot_o,
  input  logic                biu_stb_ack_i,
  input  logic                biu_ack_i,
  input  logic                biu_err_i,
  input  imem_pkg::xlen_t     biu_q_i
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  imem_pkg::biu_prot_t   prot;
  logic                  misaligned;
  logic                  pma_fault;
  logic                  pmp_fault;
  imem_pkg::chk_result_t chk;

  // Always an instruction access, privileged only in machine mode
  assign prot = imem_pkg::PROT_INSTRUCTION |
                ((prv_i == imem_pkg::PRV_M) ? imem_pkg::PROT_PRIVILEGED : '0);

  // Gather checker verdicts
  assign chk.misaligned = misaligned;
  assign chk.pma_fault  = pma_fault;
  assign chk.pmp_fault  = pmp_fault;

  ////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////

  imem_pma_chk i_pma_chk (
    .pma_cfg_i    ( pma_cfg_i   ),
    .pma_bound_i  ( pma_bound_i ),
    .adr_i        ( mem_adr_i   ),
    .misaligned_o ( misaligned  ),
    .fault_o      ( pma_fault   )
  );

  imem_pmp_chk i_pmp_chk (
    .pmp_cfg_i  ( pmp_cfg_i  ),
    .pmp_addr_i ( pmp_addr_i ),
    .prv_i      ( prv_i      ),
    .adr_i      ( mem_adr_i  ),
    .fault_o    ( pmp_fault  )
  );

  ////////////////////////////////////////
  // Fetch core
  ////////////////////////////////////////

  imem_fetch_core i_fetch_core (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .mem_req_i      ( mem_req_i      ),
    .mem_adr_i      ( mem_adr_i      ),
    .mem_flush_i    ( mem_flush_i    ),
    .chk_i          ( chk            ),
    .prot_i         ( prot           ),
    .mem_ack_o      ( mem_ack_o      ),
    .parcel_valid_o ( parcel_valid_o ),
    .parcel_o       ( parcel_o       ),
    .biu_stb_o      ( biu_stb_o      ),
    .biu_stb_ack_i  ( biu_stb_ack_i  ),
    .biu_adr_o      ( biu_adr_o      ),
    .biu_prot_o     ( biu_prot_o     ),
    .biu_ack_i      ( biu_ack_i      ),
    .biu_err_i      ( biu_err_i      ),
    .biu_q_i        ( biu_q_i        )
  );

endmodule

// File: dv/tb_imem_bus_model.sv
// BIU responder with random strobe stall, in-order delayed responses and an error window
`timescale 1ns/100ps

module tb_imem_bus_model
(
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Addresses in [err_lo_i, err_hi_i) answer with a bus error
  input  imem_pkg::paddr_t err_lo_i,
  input  imem_pkg::paddr_t err_hi_i,

  // BIU strobe side
  input  logic             biu_stb_i,
  input  imem_pkg::paddr_t biu_adr_i,
  output logic             biu_stb_ack_o,

  // BIU response side
  output logic             biu_ack_o,
  output logic             biu_err_o,
  output imem_pkg::xlen_t  biu_q_o
);

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  // Pending responses, oldest first
  imem_pkg::paddr_t rsp_adr [$];
  int               rsp_due [$];

  int               cyc;
  int               stall;
  int               due;
  int               last_due;
  logic             stalling;
  logic             rst_seen;
  imem_pkg::paddr_t adr;

  initial
  begin
    biu_stb_ack_o = 1'b0;
    biu_ack_o     = 1'b0;
    biu_err_o     = 1'b0;
    biu_q_o       = '0;
    cyc           = 0;
    stall         = 0;
    last_due      = 0;
    stalling      = 1'b0;
  end

  ////////////////////////////////////////
  // Responder
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin
    // Reset level as seen at the edge
    rst_seen = rst_n_i;
    // Drive 1 ns after the edge
    #1;
    biu_stb_ack_o = 1'b0;
    biu_ack_o     = 1'b0;
    biu_err_o     = 1'b0;
    biu_q_o       = '0;
    if (!rst_seen)
    begin
      cyc      = 0;
      last_due = 0;
      stalling = 1'b0;
      rsp_adr.delete();
      rsp_due.delete();
    end
    else
    begin
      cyc++;
      // Strobe taken after 0 to 3 wait cycles
      if (biu_stb_i)
      begin
        if (!stalling)
        begin
          stall    = $urandom_range(3, 0);
          stalling = 1'b1;
        end
        if (stall == 0)
        begin
          biu_stb_ack_o = 1'b1;
          stalling      = 1'b0;
          // Response 1 to 4 cycles later, never overtaking an older one
          due = cyc + $urandom_range(4, 1);
          if (due <= last_due)
            due = last_due + 1;
          last_due = due;
          rsp_adr.push_back(biu_adr_i);
          rsp_due.push_back(due);
        end
        else
          stall--;
      end

      // Oldest response once its cycle has come
      if (rsp_due.size() != 0 && rsp_due[0] <= cyc)
      begin
        adr = rsp_adr.pop_front();
        void'(rsp_due.pop_front());
        // Data carries the address so the parcel can be traced
        biu_q_o = adr ^ 32'hA5A5_0000;
        if (adr >= err_lo_i && adr < err_hi_i)
          biu_err_o = 1'b1;
        else
          biu_ack_o = 1'b1;
      end
    end
  end

endmodule

// File: dv/tb_imem_ctrl.sv
// Testbench top with clock, reset, directed and random fetches, reference model and scoreboard
`timescale 1ns/100ps

module tb_imem_ctrl;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // Cycles any single wait may take
  localparam int               WAIT_LIMIT = 400;
  // Bus error window
  localparam imem_pkg::paddr_t ERR_LO     = 32'h0000_3000;
  localparam imem_pkg::paddr_t ERR_HI     = 32'h0000_3100;
  // Bus data is the address with this pattern
  localparam imem_pkg::xlen_t  DATA_XOR   = 32'hA5A5_0000;

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  logic                clk;
  logic                rst_n;

  imem_pkg::pma_cfg_t  pma_cfg   [imem_pkg::PMA_CNT];
  imem_pkg::paddr_t    pma_bound [imem_pkg::PMA_CNT];
  imem_pkg::pmp_cfg_t  pmp_cfg   [imem_pkg::PMP_CNT];
  imem_pkg::paddr_t    pmp_addr  [imem_pkg::PMP_CNT];
  imem_pkg::prv_e      prv;

  logic                mem_req;
  imem_pkg::paddr_t    mem_adr;
  logic                mem_flush;
  logic                mem_ack;
  logic                parcel_valid;
  imem_pkg::parcel_t   parcel;

  logic                biu_stb;
  imem_pkg::paddr_t    biu_adr;
  imem_pkg::biu_prot_t biu_prot;
  logic                biu_stb_ack;
  logic                biu_ack;
  logic                biu_err;
  imem_pkg::xlen_t     biu_q;

  // Expected parcels of accepted requests with the oldest first
  imem_pkg::parcel_t   exp_q [$];

  ////////////////////////////////////////
  // DUT and bus model
  ////////////////////////////////////////

  imem_ctrl i_dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .pma_cfg_i      ( pma_cfg      ),
    .pma_bound_i    ( pma_bound    ),
    .pmp_cfg_i      ( pmp_cfg      ),
    .pmp_addr_i     ( pmp_addr     ),
    .prv_i          ( prv          ),
    .mem_req_i      ( mem_req      ),
    .mem_adr_i      ( mem_adr      ),
    .mem_flush_i    ( mem_flush    ),
    .mem_ack_o      ( mem_ack      ),
    .parcel_valid_o ( parcel_valid ),
    .parcel_o       ( parcel       ),
    .biu_stb_o      ( biu_stb      ),
    .biu_adr_o      ( biu_adr      ),
    .biu_prot_o     ( biu_prot     ),
    .biu_stb_ack_i  ( biu_stb_ack  ),
    .biu_ack_i      ( biu_ack      ),
    .biu_err_i      ( biu_err      ),
    .biu_q_i        ( biu_q        )
  );

  tb_imem_bus_model i_bus (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .err_lo_i      ( ERR_LO      ),
    .err_hi_i      ( ERR_HI      ),
    .biu_stb_i     ( biu_stb     ),
    .biu_adr_i     ( biu_adr     ),
    .biu_stb_ack_o ( biu_stb_ack ),
    .biu_ack_o     ( biu_ack     ),
    .biu_err_o     ( biu_err     ),
    .biu_q_o       ( biu_q       )
  );

  // 10 ns clock
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Fetch rejected by alignment, PMA or PMP rules
  function automatic logic check_fault(
    input imem_pkg::paddr_t   adr,
    input imem_pkg::prv_e     prv_lvl,
    input imem_pkg::pma_cfg_t ma_cfg   [imem_pkg::PMA_CNT],
    input imem_pkg::paddr_t   ma_bound [imem_pkg::PMA_CNT],
    input imem_pkg::pmp_cfg_t mp_cfg   [imem_pkg::PMP_CNT],
    input imem_pkg::paddr_t   mp_addr  [imem_pkg::PMP_CNT]
  );
    imem_pkg::paddr_t base;
    logic             ma_hit;
    logic             ma_exec;
    logic             mp_hit;
    logic             mp_lock;
    logic             mp_exec;
    logic             mp_bad;

    ma_hit  = 1'b0;
    ma_exec = 1'b0;
    mp_hit  = 1'b0;
    mp_lock = 1'b0;
    mp_exec = 1'b0;

    // PMA region i spans previous bound up to its own bound
    for (int i = 0; i < imem_pkg::PMA_CNT; i++)
    begin
      base = (i == 0) ? '0 : ma_bound[i-1];
      if (!ma_hit && ma_cfg[i].valid && adr >= base && adr < ma_bound[i])
      begin
        ma_hit  = 1'b1;
        ma_exec = ma_cfg[i].exec;
      end
    end

    // Lowest TOR entry wins
    for (int i = 0; i < imem_pkg::PMP_CNT; i++)
    begin
      base = (i == 0) ? '0 : mp_addr[i-1];
      if (!mp_hit && mp_cfg[i].tor && adr >= base && adr < mp_addr[i])
      begin
        mp_hit  = 1'b1;
        mp_lock = mp_cfg[i].lock;
        mp_exec = mp_cfg[i].exec;
      end
    end

    if (prv_lvl == imem_pkg::PRV_M)
      mp_bad = mp_hit && mp_lock && !mp_exec;
    else
      mp_bad = !mp_hit || !mp_exec;

    return (adr[1:0] != 2'b00) || !ma_hit || !ma_exec || mp_bad;
  endfunction

  // Parcel the DUT must return for a fetch
  function automatic imem_pkg::parcel_t expected_parcel(
    input imem_pkg::paddr_t   adr,
    input imem_pkg::prv_e     prv_lvl,
    input imem_pkg::pma_cfg_t ma_cfg   [imem_pkg::PMA_CNT],
    input imem_pkg::paddr_t   ma_bound [imem_pkg::PMA_CNT],
    input imem_pkg::pmp_cfg_t mp_cfg   [imem_pkg::PMP_CNT],
    input imem_pkg::paddr_t   mp_addr  [imem_pkg::PMP_CNT]
  );
    imem_pkg::parcel_t p;

    p.pc         = adr;
    p.data       = '0;
    p.error      = 1'b1;
    p.misaligned = (adr[1:0] != 2'b00);
    if (!check_fault(adr, prv_lvl, ma_cfg, ma_bound, mp_cfg, mp_addr))
    begin
      p.misaligned = 1'b0;
      // Bus error keeps zero data
      if (!(adr >= ERR_LO && adr < ERR_HI))
      begin
        p.error = 1'b0;
        p.data  = adr ^ DATA_XOR;
      end
    end
    return p;
  endfunction

  // Instruction access that is privileged in machine mode
  function automatic imem_pkg::biu_prot_t expected_prot(input imem_pkg::prv_e prv_lvl);
    if (prv_lvl == imem_pkg::PRV_M)
      return imem_pkg::PROT_INSTRUCTION | imem_pkg::PROT_PRIVILEGED;
    else
      return imem_pkg::PROT_INSTRUCTION;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_parcel(input imem_pkg::parcel_t got, input imem_pkg::parcel_t exp);
    if (got !== exp)
    begin
      $display("ERROR %0t: parcel pc=%h data=%h err=%b mis=%b, expected pc=%h data=%h err=%b mis=%b",
               $time, got.pc, got.data, got.error, got.misaligned,
               exp.pc, exp.data, exp.error, exp.misaligned);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_prot(input imem_pkg::biu_prot_t got, input imem_pkg::biu_prot_t exp);
    if (got !== exp)
    begin
      $display("ERROR %0t: biu_prot_o is %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////

  // Sampled mid-cycle when all inputs have settled
  always @(negedge clk)
  begin : scoreboard
    if (rst_n)
    begin
      // Parcels of this cycle predate any flush in it
      if (parcel_valid)
      begin
        check_bit(exp_q.size() != 0, 1'b1, "parcel with a request outstanding");
        if (exp_q.size() != 0)
          check_parcel(parcel, exp_q.pop_front());
      end
      if (mem_flush)
        exp_q.delete();
      if (mem_ack)
        exp_q.push_back(expected_parcel(mem_adr, prv, pma_cfg, pma_bound, pmp_cfg, pmp_addr));
      check_bit(exp_q.size() <= imem_pkg::QUEUE_DEPTH, 1'b1, "outstanding count within two");

      // Bus accesses only for clean fetches
      if (biu_stb && biu_stb_ack)
      begin
        check_bit(check_fault(biu_adr, prv, pma_cfg, pma_bound, pmp_cfg, pmp_addr), 1'b0,
                  "fault flag of strobed address");
        check_prot(biu_prot, expected_prot(prv));
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Hold a request until the DUT takes it
  task automatic issue_fetch(input imem_pkg::paddr_t adr);
    int cycles;

    cycles = 0;
    @(posedge clk);
    #1;
    mem_req = 1'b1;
    mem_adr = adr;
    @(negedge clk);
    while (!mem_ack)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("Timeout: fetch of address %h was never accepted", adr);
        abort_run();
      end
      else
      begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      mem_req = 1'b0;
    end
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    #1;
    mem_req   = 1'b0;
    mem_flush = 1'b1;
    @(posedge clk);
    #1;
    mem_flush = 1'b0;
  endtask

  // New privilege driven with the other inputs after an edge
  task automatic set_privilege(input imem_pkg::prv_e prv_lvl);
    @(posedge clk);
    #1;
    prv = prv_lvl;
  endtask

  // All parcels back and no strobe on the bus
  task automatic wait_drain();
    int cycles;

    cycles = 0;
    idle_cycles(1);
    @(negedge clk);
    while (exp_q.size() != 0 || biu_stb)
    begin
      if (cycles == WAIT_LIMIT)
      begin
        $display("Timeout: %0d parcels never returned or strobe never taken", exp_q.size());
        abort_run();
      end
      else
      begin
        cycles++;
        @(negedge clk);
      end
    end
  endtask

  // Random fetches over all regions and mostly aligned
  task automatic random_fetches(input int n);
    imem_pkg::paddr_t adr;

    repeat (n)
    begin
      adr = imem_pkg::paddr_t'($urandom_range(32'h0000_43FF, 0));
      if ($urandom_range(7, 0) != 0)
        adr[1:0] = 2'b00;
      issue_fetch(adr);
      idle_cycles($urandom_range(2, 0));
    end
    wait_drain();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin : stimulus
    void'($urandom(32'h786a));
    clk       = 1'b0;
    rst_n     = 1'b0;
    mem_req   = 1'b0;
    mem_adr   = '0;
    mem_flush = 1'b0;
    prv       = imem_pkg::PRV_M;

    // PMA regions exec then non-exec then exec with nothing above 0x4000
    pma_cfg[0]   = '{valid: 1'b1, exec: 1'b1};
    pma_bound[0] = 32'h0000_1000;
    pma_cfg[1]   = '{valid: 1'b1, exec: 1'b0};
    pma_bound[1] = 32'h0000_2000;
    pma_cfg[2]   = '{valid: 1'b1, exec: 1'b1};
    pma_bound[2] = 32'h0000_4000;

    // PMP entries open then locked no-exec then open then unlocked no-exec
    // No entry above 0x3800
    pmp_cfg[0]  = '{lock: 1'b0, tor: 1'b1, exec: 1'b1};
    pmp_addr[0] = 32'h0000_0800;
    pmp_cfg[1]  = '{lock: 1'b1, tor: 1'b1, exec: 1'b0};
    pmp_addr[1] = 32'h0000_0C00;
    pmp_cfg[2]  = '{lock: 1'b0, tor: 1'b1, exec: 1'b1};
    pmp_addr[2] = 32'h0000_2800;
    pmp_cfg[3]  = '{lock: 1'b0, tor: 1'b1, exec: 1'b0};
    pmp_addr[3] = 32'h0000_3800;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(mem_ack, 1'b0, "mem_ack_o after reset");
    check_bit(biu_stb, 1'b0, "biu_stb_o after reset");
    check_bit(parcel_valid, 1'b0, "parcel_valid_o after reset");

    // Clean machine mode fetches back to back
    issue_fetch(32'h0000_0000);
    issue_fetch(32'h0000_0004);
    issue_fetch(32'h0000_0100);
    issue_fetch(32'h0000_2000);
    issue_fetch(32'h0000_2804);
    issue_fetch(32'h0000_3800);
    wait_drain();

    // Misaligned, PMA, locked PMP and bus error cases
    issue_fetch(32'h0000_0102);
    issue_fetch(32'h0000_0001);
    issue_fetch(32'h0000_1000);
    issue_fetch(32'h0000_5000);
    issue_fetch(32'h0000_0800);
    issue_fetch(32'h0000_3000);
    issue_fetch(32'h0000_0200);
    issue_fetch(32'h0000_30FC);
    wait_drain();

    // User mode fetches with privilege changed only while idle
    set_privilege(imem_pkg::PRV_U);
    issue_fetch(32'h0000_0004);
    issue_fetch(32'h0000_0C00);
    issue_fetch(32'h0000_2800);
    issue_fetch(32'h0000_3900);
    issue_fetch(32'h0000_0804);
    issue_fetch(32'h0000_2000);
    wait_drain();

    random_fetches(50);
    set_privilege(imem_pkg::PRV_M);
    random_fetches(50);

    // Flush with clean and faulted fetches in flight
    repeat (8)
    begin
      issue_fetch(imem_pkg::paddr_t'($urandom_range(255, 0)) << 2);
      issue_fetch(imem_pkg::paddr_t'($urandom_range(255, 0)) << 2);
      issue_fetch(32'h0000_1000);
      idle_cycles($urandom_range(3, 0));
      pulse_flush();
      // Fresh addresses make any stale parcel show up as a mismatch
      repeat (3)
        issue_fetch(32'h0000_2000 + (imem_pkg::paddr_t'($urandom_range(255, 0)) << 2));
      wait_drain();
    end

    // Room for stray parcels
    idle_cycles(20);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: all.f
common/imem_pkg.sv
hdl/imem_pma_chk.sv
hdl/imem_pmp_chk.sv
fetch/imem_fetch_core.sv
hdl/imem_ctrl.sv
dv/tb_imem_bus_model.sv
dv/tb_imem_ctrl.sv
